//--- compile.f
rtl/cmt_pkg.sv
rtl/cmt_select.sv
rtl/cmt_mem_port.sv
rtl/cmt_top.sv
test/cmt_tb_mem.sv
test/cmt_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module cmt_tb -f compile.f -o cmt_sim \
   && ./obj_dir/cmt_sim 2>&1 | tee sim.log \
   && grep -q "^Simulation passed$" sim.log \
   || { echo "run.sh: simulation did not pass"; exit 1; }

//--- test/cmt_tb.sv
// Commit stage testbench

module cmt_tb
   import cmt_pkg::*;
();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          NS          = 4;             // Commit slots
   localparam logic [31:0] SEED        = 32'hbe0a4e47;
   localparam int          ACK_TIMEOUT = 32;            // Cycles per bus wait

   logic                clk = 1'b0;
   logic                rst;
   logic [NS-1:0]       cmt_valid;
   lsu_op_t [NS-1:0]    cmt_lsu_op;
   logic [NS-1:0]       cmt_is_br;
   logic [NS-1:0]       cmt_fls;
   logic [PC_W-1:0]     cmt_pc0;
   logic [PC_W-1:0]     cmt_fls_tgt0;
   logic                bpu_pred_taken;
   logic [PC_W-1:0]     bpu_pred_tgt;
   logic [DW-1:0]       cmt_opera0;
   logic [DW-1:0]       cmt_operb0;
   logic [PRF_AW-1:0]   cmt_prd0;
   logic                cmt_prd_we0;
   logic [NS-1:0]       cmt_fire;
   logic [2:0]          cmt_pop_size;
   logic                flush;
   logic [PC_W-1:0]     flush_tgt;
   logic                bpu_wb;
   logic                bpu_wb_taken;
   logic [PC_W-1:0]     bpu_wb_pc;
   logic [PC_W-1:0]     bpu_wb_npc_act;
   logic                wb_cyc;
   logic                wb_stb;
   logic                wb_we;
   logic [AW-1:0]       wb_adr;
   logic [DW-1:0]       wb_dat_w;
   logic [DW-1:0]       wb_dat_r;
   logic                wb_ack;
   logic                prf_we;
   logic [PRF_AW-1:0]   prf_waddr;
   logic [DW-1:0]       prf_wdata;
   logic [1:0]          ws;
   logic [31:0]         seed;
   int                  errors = 0;
   int                  errs_seen = 0;
   int                  tests = 0;
   int                  failed = 0;
   logic                hung = 1'b0;     // A bus wait timed out
   logic [DW-1:0]       ld_expect;
   logic [NS-1:0]       sgl;
   logic                stall;
   logic [NS-1:0]       exp_fire;
   logic                exp_fls;
   logic [PC_W-1:0]     exp_tgt;
   logic [2*PC_W:0]     exp_bpu;

   cmt_top #(.P_COMMIT_WIDTH(2)) cmt_top_i (.*);
   cmt_tb_mem mem_i (.*);

   always #2 clk = ~clk;

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      seed = xorshift(seed);
      return seed;
   endfunction

   // Slot 0 always; slot 1 needs both of the first two plain; then a chain
   function automatic logic [NS-1:0] ref_mask(input logic [NS-1:0] s);
      logic [NS-1:0] m;
      m[0] = 1'b1;
      m[1] = ~s[0] & ~s[1];
      for (int i = 2; i < NS; i++)
      begin
         m[i] = m[i-1] & ~s[i];
      end
      return m;
   endfunction

   always_comb
   begin
      for (int i = 0; i < NS; i++)
      begin
         sgl[i] = (cmt_lsu_op[i] != LSU_NONE) | cmt_fls[i] | cmt_is_br[i];
      end
   end

   assign stall    = cmt_valid[0] & (cmt_lsu_op[0] != LSU_NONE) & ~wb_ack;  // Bus not done
   assign exp_fire = (exp_fls | stall) ? '0 : (cmt_valid & ref_mask(sgl));

   // A redirecting branch went the other way, to the redirect target
   always_comb
   begin
      if (cmt_fls[0])
         exp_bpu = {~bpu_pred_taken, cmt_pc0, cmt_fls_tgt0};
      else
         exp_bpu = {bpu_pred_taken, cmt_pc0, bpu_pred_tgt};
   end

   // Flush follows a redirecting slot 0 by one cycle
   always @(posedge clk)
   begin
      exp_fls <= ~rst & exp_fire[0] & cmt_fls[0];
      if (exp_fire[0])
         exp_tgt <= cmt_fls_tgt0;
   end

   task automatic report_value(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
      errors++;
      $display("ERROR %0t: %s expected %0h, got %0h", $time, name, exp, got);
   endtask

   task automatic report_fault(input string what);
      errors++;
      $display("%0t: %s", $time, what);
   endtask

   a_reset: assert property (@(posedge clk) $fell(rst) |->
         {flush, wb_cyc, wb_stb, bpu_wb, prf_we, cmt_pop_size} == '0)
      else report_value("flush,wb_cyc,wb_stb,bpu_wb,prf_we,cmt_pop_size", 64'(0),
         64'($sampled({flush, wb_cyc, wb_stb, bpu_wb, prf_we, cmt_pop_size})));
   a_fire: assert property (@(posedge clk) disable iff (rst) cmt_fire == exp_fire)
      else report_value("cmt_fire", 64'($sampled(exp_fire)), 64'($sampled(cmt_fire)));
   a_pop: assert property (@(posedge clk) disable iff (rst)
         cmt_pop_size == 3'($countones(exp_fire)))
      else report_value("cmt_pop_size", 64'($countones($sampled(exp_fire))),
         64'($sampled(cmt_pop_size)));
   a_hold: assert property (@(posedge clk) disable iff (rst) wb_cyc && !wb_ack |-> cmt_fire == '0)
      else report_value("cmt_fire", 64'(0), 64'($sampled(cmt_fire)));
   a_flush: assert property (@(posedge clk) disable iff (rst) flush == exp_fls)
      else report_value("flush", 64'($sampled(exp_fls)), 64'($sampled(flush)));
   a_flush_tgt: assert property (@(posedge clk) disable iff (rst) flush |-> flush_tgt == exp_tgt)
      else report_value("flush_tgt", 64'($sampled(exp_tgt)), 64'($sampled(flush_tgt)));
   a_bpu: assert property (@(posedge clk) disable iff (rst)
         bpu_wb == (exp_fire[0] & cmt_is_br[0]))
      else report_value("bpu_wb", 64'($sampled(exp_fire[0] & cmt_is_br[0])),
         64'($sampled(bpu_wb)));
   a_bpu_vals: assert property (@(posedge clk) disable iff (rst)
         bpu_wb |-> {bpu_wb_taken, bpu_wb_pc, bpu_wb_npc_act} == exp_bpu)
      else report_value("bpu_wb_taken,bpu_wb_pc,bpu_wb_npc_act", 64'($sampled(exp_bpu)),
         64'($sampled({bpu_wb_taken, bpu_wb_pc, bpu_wb_npc_act})));
   a_start: assert property (@(posedge clk) disable iff (rst)
         $past(cmt_valid[0] && cmt_lsu_op[0] != LSU_NONE && !wb_cyc && !exp_fls) |-> wb_cyc)
      else report_fault("wb_cyc did not rise after a slot 0 load or store");
   a_adr: assert property (@(posedge clk) disable iff (rst) wb_cyc |-> wb_adr == cmt_opera0)
      else report_value("wb_adr", 64'($sampled(cmt_opera0)), 64'($sampled(wb_adr)));
   a_we: assert property (@(posedge clk) disable iff (rst)
         wb_cyc |-> {wb_stb, wb_we} == {1'b1, cmt_lsu_op[0] == LSU_STORE})
      else report_value("wb_stb,wb_we", 64'({1'b1, $sampled(cmt_lsu_op[0]) == LSU_STORE}),
         64'($sampled({wb_stb, wb_we})));
   a_dat: assert property (@(posedge clk) disable iff (rst)
         wb_cyc && wb_we |-> wb_dat_w == cmt_operb0)
      else report_value("wb_dat_w", 64'($sampled(cmt_operb0)), 64'($sampled(wb_dat_w)));
   a_stable: assert property (@(posedge clk) disable iff (rst) $past(wb_cyc && !wb_ack) |->
         wb_cyc && $stable({wb_adr, wb_we, wb_dat_w}))
      else report_fault("bus request dropped or changed before the acknowledge");
   a_end: assert property (@(posedge clk) disable iff (rst) $past(wb_cyc && wb_ack) |-> !wb_cyc)
      else report_fault("wb_cyc still high in the cycle after the acknowledge");
   a_prf: assert property (@(posedge clk) disable iff (rst)
         prf_we == (wb_cyc && wb_ack && cmt_lsu_op[0] == LSU_LOAD && cmt_prd_we0))
      else report_value("prf_we",
         64'($sampled(wb_cyc && wb_ack && cmt_lsu_op[0] == LSU_LOAD && cmt_prd_we0)),
         64'($sampled(prf_we)));
   a_prf_vals: assert property (@(posedge clk) disable iff (rst)
         prf_we |-> {prf_waddr, prf_wdata} == {cmt_prd0, ld_expect})
      else report_value("prf_waddr,prf_wdata", 64'($sampled({cmt_prd0, ld_expect})),
         64'($sampled({prf_waddr, prf_wdata})));

   task automatic step();
      @(posedge clk);
      #0.5;
   endtask

   task automatic end_test(input string name);
      tests++;
      if (errors != errs_seen)
         failed++;
      $display("test %-16s %s", name, (errors == errs_seen) ? "ok" : "has errors");
      errs_seen = errors;
   endtask

   // One cycle of plain slots with fresh slot 0 fields
   task automatic present(input logic [NS-1:0] v, input logic [NS-1:0] br,
                          input logic [NS-1:0] fl);
      logic [31:0] r;
      r = next_rand();
      cmt_valid      = v;
      cmt_is_br      = br;
      cmt_fls        = fl;
      cmt_pc0        = PC_W'(next_rand());
      cmt_fls_tgt0   = PC_W'(next_rand());
      bpu_pred_taken = r[0];
      bpu_pred_tgt   = PC_W'(next_rand());
      step();
   endtask

   // dat is the store data, or the expected read for a load
   task automatic mem_op(input lsu_op_t op, input logic [AW-1:0] adr,
                         input logic [DW-1:0] dat, input logic [NS-1:0] v);
      logic        acked;
      logic [31:0] r;
      acked = 1'b0;
      r = next_rand();
      if (!hung)
      begin
         cmt_valid     = v | 4'b0001;
         cmt_is_br     = '0;
         cmt_fls       = '0;
         cmt_lsu_op[0] = op;
         cmt_opera0    = adr;
         cmt_operb0    = (op == LSU_STORE) ? dat : next_rand();
         ld_expect     = dat;
         cmt_prd0      = r[5:0];
         cmt_prd_we0   = (r[7:6] != 2'b00);
         ws            = r[9:8];
         for (int n = 0; n < ACK_TIMEOUT && !acked; n++)
         begin
            acked = wb_cyc & wb_ack;  // Inputs held through the ack cycle
            step();
         end
         if (!acked)
         begin
            hung = 1'b1;
            report_fault("timeout waiting for the bus acknowledge");
         end
         cmt_valid     = '0;
         cmt_lsu_op[0] = LSU_NONE;
      end
   endtask

   initial
   begin
      logic [31:0]   r;
      logic [AW-1:0] st_adr [6];
      logic [DW-1:0] st_dat [6];
      $timeformat(-9, 1, " ns", 8);
      seed = SEED;
      rst = 1'b1;
      ws = 2'd0;
      cmt_valid = '0;
      cmt_is_br = '0;
      cmt_fls = '0;
      for (int i = 0; i < NS; i++)
         cmt_lsu_op[i] = LSU_NONE;
      cmt_pc0 = '0;
      cmt_fls_tgt0 = '0;
      bpu_pred_taken = 1'b0;
      bpu_pred_tgt = '0;
      cmt_opera0 = '0;
      cmt_operb0 = '0;
      cmt_prd0 = '0;
      cmt_prd_we0 = 1'b0;
      ld_expect = '0;
      repeat (4) step();
      rst = 1'b0;
      repeat (2) step();
      end_test("reset");

      for (int i = 0; i < 300; i++)
      begin
         r = next_rand();
         present(r[3:0], r[7:4] & r[11:8], r[15:12] & r[19:16] & r[23:20]);
      end
      end_test("commit_mask");

      present(4'b0011, 4'b0000, 4'b0001);  // Slot 0 redirects
      present(4'b1111, 4'b0000, 4'b0000);  // Flush cycle retires nothing
      present(4'b1111, 4'b0000, 4'b0000);
      present(4'b0001, 4'b0001, 4'b0001);
      present(4'b0001, 4'b0000, 4'b0001);  // Lands in the flush cycle
      present(4'b0000, 4'b0000, 4'b0000);
      end_test("flush");

      present(4'b0001, 4'b0001, 4'b0000);
      present(4'b0001, 4'b0001, 4'b0001);  // Mispredicted branch
      present(4'b0000, 4'b0000, 4'b0000);
      present(4'b1101, 4'b0100, 4'b0000);
      present(4'b0111, 4'b0001, 4'b0000);
      end_test("branch_update");

      for (int i = 0; i < 6; i++)
      begin
         r = next_rand();
         st_adr[i] = AW'({r[4:0], 3'(i), 2'b00});  // Distinct words
         st_dat[i] = next_rand();
         mem_op(LSU_STORE, st_adr[i], st_dat[i], 4'b1111);
      end
      for (int i = 0; i < 6; i++)
         mem_op(LSU_LOAD, st_adr[i], st_dat[i], 4'b1111);
      end_test("store_load");

      for (int i = 0; i < 10; i++)
      begin
         r = next_rand();
         if (r[8])
            mem_op(LSU_STORE, AW'({r[7:0], 2'b00}), next_rand(), r[15:12]);
         else
            mem_op(LSU_LOAD, AW'({r[7:0], 2'b00}), mem_i.mem[r[7:0]], r[15:12]);
      end
      step();
      end_test("back_pressure");

      $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

//--- test/cmt_tb_mem.sv
// Wishbone slave memory model

module cmt_tb_mem
   import cmt_pkg::*;
(
   input  logic            clk,
   input  logic            rst,
   input  logic [1:0]      ws,         // Wait states for the next bus cycle
   input  logic            wb_cyc,
   input  logic            wb_stb,
   input  logic            wb_we,
   input  logic [AW-1:0]   wb_adr,
   input  logic [DW-1:0]   wb_dat_w,
   output logic [DW-1:0]   wb_dat_r,
   output logic            wb_ack
);
   timeunit 1ns;
   timeprecision 100ps;

   logic [DW-1:0] mem [256];  // Word addressed by wb_adr[9:2]
   logic          busy;
   logic [1:0]    wait_cnt;

   always @(posedge clk)
   begin
      wb_ack <= 1'b0;
      if (rst)
      begin
         busy <= 1'b0;
         for (int i = 0; i < 256; i++)
         begin
            mem[i] <= {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3};  // Unique per word
         end
      end
      else if (wb_cyc && wb_stb && !wb_ack)
      begin
         if (!busy)
         begin
            busy     <= 1'b1;
            wait_cnt <= ws;  // Latency fixed for the whole cycle
         end
         else if (wait_cnt != 2'd0)
         begin
            wait_cnt <= wait_cnt - 2'd1;
         end
         else
         begin
            busy   <= 1'b0;
            wb_ack <= 1'b1;
            if (wb_we)
               mem[wb_adr[9:2]] <= wb_dat_w;
            else
               wb_dat_r <= mem[wb_adr[9:2]];
         end
      end
   end

endmodule

//--- rtl/cmt_top.sv
// Commit stage top level

module cmt_top
   import cmt_pkg::*;
#(
   parameter int P_COMMIT_WIDTH = 2
)
(
   input  logic                      clk,
   input  logic                      rst,
   // Reorder buffer heads
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]    cmt_valid,
   input  lsu_op_t [(1<<P_COMMIT_WIDTH)-1:0] cmt_lsu_op,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]    cmt_is_br,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]    cmt_fls,
   // Slot 0 fields
   input  logic [PC_W-1:0]           cmt_pc0,
   input  logic [PC_W-1:0]           cmt_fls_tgt0,
   input  logic                      bpu_pred_taken,
   input  logic [PC_W-1:0]           bpu_pred_tgt,
   input  logic [DW-1:0]             cmt_opera0,
   input  logic [DW-1:0]             cmt_operb0,
   input  logic [PRF_AW-1:0]         cmt_prd0,
   input  logic                      cmt_prd_we0,
   // To the reorder buffer
   output logic [(1<<P_COMMIT_WIDTH)-1:0]    cmt_fire,
   output logic [P_COMMIT_WIDTH:0]   cmt_pop_size,
   // Pipeline flush
   output logic                      flush,
   output logic [PC_W-1:0]           flush_tgt,
   // Branch predictor update
   output logic                      bpu_wb,
   output logic                      bpu_wb_taken,
   output logic [PC_W-1:0]           bpu_wb_pc,
   output logic [PC_W-1:0]           bpu_wb_npc_act,
   // Wishbone data bus
   output logic                      wb_cyc,
   output logic                      wb_stb,
   output logic                      wb_we,
   output logic [AW-1:0]             wb_adr,
   output logic [DW-1:0]             wb_dat_w,
   input  logic [DW-1:0]             wb_dat_r,
   input  logic                      wb_ack,
   // Register file write
   output logic                      prf_we,
   output logic [PRF_AW-1:0]         prf_waddr,
   output logic [DW-1:0]             prf_wdata
);

   logic mem_req;   // Slot 0 load or store waiting
   logic mem_done;  // Bus acknowledge

   cmt_select #(
      .P_COMMIT_WIDTH (P_COMMIT_WIDTH)
   ) cmt_select_i (
      .clk            (clk),
      .rst            (rst),
      .cmt_valid      (cmt_valid),
      .cmt_lsu_op     (cmt_lsu_op),
      .cmt_is_br      (cmt_is_br),
      .cmt_fls        (cmt_fls),
      .cmt_pc0        (cmt_pc0),
      .cmt_fls_tgt0   (cmt_fls_tgt0),
      .bpu_pred_taken (bpu_pred_taken),
      .bpu_pred_tgt   (bpu_pred_tgt),
      .cmt_fire       (cmt_fire),
      .cmt_pop_size   (cmt_pop_size),
      .flush          (flush),
      .flush_tgt      (flush_tgt),
      .mem_req        (mem_req),
      .mem_done       (mem_done),
      .bpu_wb         (bpu_wb),
      .bpu_wb_taken   (bpu_wb_taken),
      .bpu_wb_pc      (bpu_wb_pc),
      .bpu_wb_npc_act (bpu_wb_npc_act)
   );

   cmt_mem_port cmt_mem_port_i (
      .clk         (clk),
      .rst         (rst),
      .mem_req     (mem_req),
      .mem_done    (mem_done),
      .cmt_lsu_op0 (cmt_lsu_op[0]),  // Only the oldest slot reaches the bus
      .cmt_opera0  (cmt_opera0),
      .cmt_operb0  (cmt_operb0),
      .cmt_prd0    (cmt_prd0),
      .cmt_prd_we0 (cmt_prd_we0),
      .wb_cyc      (wb_cyc),
      .wb_stb      (wb_stb),
      .wb_we       (wb_we),
      .wb_adr      (wb_adr),
      .wb_dat_w    (wb_dat_w),
      .wb_dat_r    (wb_dat_r),
      .wb_ack      (wb_ack),
      .prf_we      (prf_we),
      .prf_waddr   (prf_waddr),
      .prf_wdata   (prf_wdata)
   );

endmodule

//--- rtl/cmt_mem_port.sv
// Commit memory port with Wishbone master

module cmt_mem_port
   import cmt_pkg::*;
(
   input  logic                clk,
   input  logic                rst,
   // Selector handshake
   input  logic                mem_req,
   output logic                mem_done,
   // Slot 0 operands
   input  lsu_op_t             cmt_lsu_op0,
   input  logic [DW-1:0]       cmt_opera0,   // Address
   input  logic [DW-1:0]       cmt_operb0,   // Store data
   input  logic [PRF_AW-1:0]   cmt_prd0,
   input  logic                cmt_prd_we0,
   // Wishbone classic master
   output logic                wb_cyc,
   output logic                wb_stb,
   output logic                wb_we,
   output logic [AW-1:0]       wb_adr,
   output logic [DW-1:0]       wb_dat_w,
   input  logic [DW-1:0]       wb_dat_r,
   input  logic                wb_ack,
   // Register file write
   output logic                prf_we,
   output logic [PRF_AW-1:0]   prf_waddr,
   output logic [DW-1:0]       prf_wdata
);

   typedef enum logic {
      S_IDLE,
      S_PENDING
   } state_t;

   state_t         state;
   logic           start;
   logic [AW-1:0]  adr_q;
   logic [DW-1:0]  dat_q;
   logic           we_q;
   logic           load_q;

   assign start = (state == S_IDLE) & mem_req;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state <= S_IDLE;
      end
      else
      begin
         case (state)
            S_IDLE:
            begin
               if (mem_req)
               begin
                  state <= S_PENDING;
               end
            end
            S_PENDING:
            begin
               if (wb_ack)
               begin
                  state <= S_IDLE;  // Bus cycle ends next clock
               end
            end
            default:
            begin
               state <= S_IDLE;
            end
         endcase
      end
   end

   // Request is frozen for the whole bus cycle
   always_ff @(posedge clk)
   begin
      if (start)
      begin
         adr_q  <= AW'(cmt_opera0);
         dat_q  <= cmt_operb0;
         we_q   <= (cmt_lsu_op0 == LSU_STORE);
         load_q <= is_load(cmt_lsu_op0);
      end
   end

   assign wb_cyc   = (state == S_PENDING);
   assign wb_stb   = (state == S_PENDING);
   assign wb_we    = we_q;
   assign wb_adr   = adr_q;
   assign wb_dat_w = dat_q;

   assign mem_done = (state == S_PENDING) & wb_ack;

   // Load data goes straight from the bus to the register file
   assign prf_we    = mem_done & load_q & cmt_prd_we0;
   assign prf_waddr = cmt_prd0;
   assign prf_wdata = wb_dat_r;

endmodule

//--- rtl/cmt_select.sv
// Commit slot selector

module cmt_select
   import cmt_pkg::*;
#(
   parameter int P_COMMIT_WIDTH = 2
)
(
   input  logic                      clk,
   input  logic                      rst,
   // Reorder buffer heads
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]    cmt_valid,
   input  lsu_op_t [(1<<P_COMMIT_WIDTH)-1:0] cmt_lsu_op,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]    cmt_is_br,
   input  logic [(1<<P_COMMIT_WIDTH)-1:0]    cmt_fls,
   input  logic [PC_W-1:0]           cmt_pc0,
   input  logic [PC_W-1:0]           cmt_fls_tgt0,
   input  logic                      bpu_pred_taken,
   input  logic [PC_W-1:0]           bpu_pred_tgt,
   // Retire report
   output logic [(1<<P_COMMIT_WIDTH)-1:0]    cmt_fire,
   output logic [P_COMMIT_WIDTH:0]   cmt_pop_size,
   // Pipeline flush
   output logic                      flush,
   output logic [PC_W-1:0]           flush_tgt,
   // Memory port handshake
   output logic                      mem_req,
   input  logic                      mem_done,
   // Branch predictor update
   output logic                      bpu_wb,
   output logic                      bpu_wb_taken,
   output logic [PC_W-1:0]           bpu_wb_pc,
   output logic [PC_W-1:0]           bpu_wb_npc_act
);

   localparam int CW = (1 << P_COMMIT_WIDTH);  // Number of commit slots

   logic [CW-1:0]    single;         // Slot must retire alone
   logic [CW-1:0]    cmt_mask;
   logic [CW-1:0]    ready_to_fire;
   logic             cmt_ce;         // Stage enable
   logic             fls_q;
   logic [PC_W-1:0]  fls_tgt_q;
   logic             fls_d;

   // Memory ops, flushes and branches each retire on their own
   always_comb
   begin
      for (int i = 0; i < CW; i++)
      begin
         single[i] = is_mem(cmt_lsu_op[i]) | cmt_fls[i] | cmt_is_br[i];
      end
   end

   // Slot 0 always goes; a single slot 0 blocks all the rest, and any
   // single slot further up cuts the group short at that point
   always_comb
   begin
      cmt_mask[0] = 1'b1;
      for (int j = 1; j < CW; j++)
      begin
         cmt_mask[j] = cmt_mask[j-1] & ~single[j] & ~single[0];
      end
   end

   assign ready_to_fire = cmt_valid & cmt_mask;

   // Slot 0 hands its load or store to the memory port
   assign mem_req = ready_to_fire[0] & is_mem(cmt_lsu_op[0]) & ~fls_q;

   // Hold the stage until the bus acknowledges
   assign cmt_ce = ~mem_req | mem_done;

   assign cmt_fire = ready_to_fire & {CW{cmt_ce & ~fls_q}};

   // Count of retired slots
   always_comb
   begin
      cmt_pop_size = '0;
      for (int k = 0; k < CW; k++)
      begin
         cmt_pop_size = cmt_pop_size + {{P_COMMIT_WIDTH{1'b0}}, cmt_fire[k]};
      end
   end

   // One-cycle flush; clears itself on the cycle it is active
   assign fls_d = cmt_fls[0] & ~fls_q;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         fls_q <= 1'b0;
      end
      else if (cmt_fire[0] | fls_q)
      begin
         fls_q <= fls_d;
      end
   end

   always_ff @(posedge clk)
   begin
      if (cmt_fire[0])
      begin
         fls_tgt_q <= cmt_fls_tgt0;  // Redirect target of the oldest slot
      end
   end

   assign flush     = fls_q;
   assign flush_tgt = fls_tgt_q;

   // A flushing branch was mispredicted, so its outcome is the opposite
   // of the prediction and its real next pc is the flush target
   assign bpu_wb         = cmt_fire[0] & cmt_is_br[0];
   assign bpu_wb_taken   = bpu_pred_taken ^ cmt_fls[0];
   assign bpu_wb_pc      = cmt_pc0;
   assign bpu_wb_npc_act = cmt_fls[0] ? cmt_fls_tgt0 : bpu_pred_tgt;

endmodule

//--- rtl/cmt_pkg.sv
// Commit stage shared definitions

package cmt_pkg;

   // Datapath widths
   localparam int PC_W   = 30;  // Word-aligned program counter
   localparam int DW     = 32;  // Operand and data width
   localparam int AW     = 32;  // Data bus address width
   localparam int PRF_AW = 6;   // Physical register index

   // Memory opcode carried by each commit slot
   typedef enum logic [1:0] {
      LSU_NONE  = 2'd0,
      LSU_LOAD  = 2'd1,
      LSU_STORE = 2'd2
   } lsu_op_t;

   // True for any slot that needs the data bus
   function automatic logic is_mem(lsu_op_t op);
      return (op != LSU_NONE);
   endfunction

   // Loads are the only memory ops that write back
   function automatic logic is_load(lsu_op_t op);
      return (op == LSU_LOAD);
   endfunction

endpackage
